/* hdl/tile_params.svh */
`ifndef TILE_PARAMS_SVH
`define TILE_PARAMS_SVH

// Message field widths
`define TILE_ADDR_W 16
`define TILE_DATA_W 64
`define TILE_CID_W 1
`define TILE_DID_W 8

// Local client ids behind the concentrator
`define CID_CFG 1'b0
`define CID_CLINT 1'b1

// Config block offsets
`define CFG_FREEZE_ADDR 16'h0000
`define CFG_CORE_ID_ADDR 16'h0008
`define CFG_DID_ADDR 16'h0010

// CLINT offsets
`define CLINT_MSIP_ADDR 16'h0000
`define CLINT_MTIMECMP_ADDR 16'h4000
`define CLINT_MTIME_ADDR 16'hbff8

`endif

/* hdl/tile_pkg.sv */
`include "tile_params.svh"

package tile_pkg;

   typedef enum logic [0:0]
   {
      e_mem_load  = 1'b0,
      e_mem_store = 1'b1
   } mem_opcode_e;

   // Command into the tile
   typedef struct packed
   {
      logic [`TILE_CID_W-1:0]  cid;
      mem_opcode_e             opcode;
      logic [`TILE_ADDR_W-1:0] addr;
      logic [`TILE_DATA_W-1:0] data;
   } mem_cmd_t;

   // Response out of the tile with zero data for stores
   typedef struct packed
   {
      logic [`TILE_CID_W-1:0]  cid;
      mem_opcode_e             opcode;
      logic [`TILE_ADDR_W-1:0] addr;
      logic [`TILE_DATA_W-1:0] data;
   } mem_resp_t;

endpackage

/* hdl/msg_fifo.sv */
`timescale 1ns/1ps

module msg_fifo
#(
   parameter type payload_t = tile_pkg::mem_cmd_t
)
(
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  payload_t data_i,
   input  logic     v_i,
   output logic     ready_o,
   output payload_t data_o,
   output logic     v_o,
   input  logic     yumi_i
);

   payload_t   mem_q [2];
   logic       wptr_q;
   logic       rptr_q;
   logic [1:0] count_q;
   logic       push;
   logic       pop;

   // Ready depends only on the held count
   assign ready_o = (count_q != 2'd2);
   assign v_o     = (count_q != 2'd0);
   assign data_o  = mem_q[rptr_q];
   assign push    = v_i & ready_o;
   assign pop     = yumi_i & v_o;

   always_ff @(posedge clk_i)
   begin
      if (push)
      begin
         mem_q[wptr_q] <= data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wptr_q  <= 1'b0;
         rptr_q  <= 1'b0;
         count_q <= 2'd0;
      end
      else
      begin
         if (push)
            wptr_q <= ~wptr_q;
         if (pop)
            rptr_q <= ~rptr_q;
         count_q <= count_q + {1'b0, push} - {1'b0, pop};
      end
   end

endmodule

/* hdl/mem_concentrator.sv */
`timescale 1ns/1ps

`include "tile_params.svh"

module mem_concentrator
(
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  tile_pkg::mem_cmd_t  cmd_i,
   input  logic                cmd_v_i,
   output logic                cmd_ready_o,

   output tile_pkg::mem_resp_t resp_o,
   output logic                resp_v_o,
   input  logic                resp_ready_i,

   output tile_pkg::mem_cmd_t  cfg_cmd_o,
   output logic                cfg_cmd_v_o,
   input  logic                cfg_cmd_yumi_i,

   output tile_pkg::mem_cmd_t  clint_cmd_o,
   output logic                clint_cmd_v_o,
   input  logic                clint_cmd_yumi_i,

   input  tile_pkg::mem_resp_t cfg_resp_i,
   input  logic                cfg_resp_v_i,
   output logic                cfg_resp_ready_o,

   input  tile_pkg::mem_resp_t clint_resp_i,
   input  logic                clint_resp_v_i,
   output logic                clint_resp_ready_o
);

   import tile_pkg::*;

   mem_cmd_t cmd_head;
   logic     cmd_head_v;
   logic     rr_q;
   logic     lock_q;
   logic     lock_sel_q;
   logic     sel_clint;

   msg_fifo
   #(
      .payload_t(mem_cmd_t)
   )
   u_cmd_fifo
   (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .data_i (cmd_i),
      .v_i    (cmd_v_i),
      .ready_o(cmd_ready_o),
      .data_o (cmd_head),
      .v_o    (cmd_head_v),
      .yumi_i (cfg_cmd_yumi_i | clint_cmd_yumi_i)
   );

   // Head goes to both clients but valid only to the addressed one
   assign cfg_cmd_o     = cmd_head;
   assign clint_cmd_o   = cmd_head;
   assign cfg_cmd_v_o   = cmd_head_v & (cmd_head.cid == `CID_CFG);
   assign clint_cmd_v_o = cmd_head_v & (cmd_head.cid == `CID_CLINT);

   // rr_q set means clint has priority
   always_comb
   begin
      if (lock_q)
         sel_clint = lock_sel_q;
      else if (rr_q)
         sel_clint = clint_resp_v_i | ~cfg_resp_v_i;
      else
         sel_clint = ~cfg_resp_v_i & clint_resp_v_i;
   end

   assign resp_v_o           = sel_clint ? clint_resp_v_i : cfg_resp_v_i;
   assign resp_o             = sel_clint ? clint_resp_i : cfg_resp_i;
   assign cfg_resp_ready_o   = resp_ready_i & ~sel_clint;
   assign clint_resp_ready_o = resp_ready_i & sel_clint;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rr_q       <= 1'b0;
         lock_q     <= 1'b0;
         lock_sel_q <= 1'b0;
      end
      else
      begin
         // Hold the grant until the stalled response goes out
         lock_q     <= resp_v_o & ~resp_ready_i;
         lock_sel_q <= sel_clint;
         if (resp_v_o & resp_ready_i)
            rr_q <= ~sel_clint;
      end
   end

endmodule

/* hdl/cfg_regs.sv */
`timescale 1ns/1ps

`include "tile_params.svh"

module cfg_regs
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  tile_pkg::mem_cmd_t     cmd_i,
   input  logic                   cmd_v_i,
   output logic                   cmd_yumi_o,
   output tile_pkg::mem_resp_t    resp_o,
   output logic                   resp_v_o,
   input  logic                   resp_ready_i,
   input  logic [`TILE_DID_W-1:0] did_i,
   output logic                   freeze_o,
   output logic [7:0]             core_id_o
);

   import tile_pkg::*;

   mem_resp_t               resp_li;
   logic                    resp_room;
   logic                    is_store;
   logic [`TILE_DATA_W-1:0] rdata;
   logic                    freeze_q;
   logic [7:0]              core_id_q;

   // Take a command only when its response has a slot
   assign cmd_yumi_o = cmd_v_i & resp_room;
   assign is_store   = (cmd_i.opcode == e_mem_store);

   always_comb
   begin
      case (cmd_i.addr)
         `CFG_FREEZE_ADDR:  rdata = {{(`TILE_DATA_W-1){1'b0}}, freeze_q};
         `CFG_CORE_ID_ADDR: rdata = {{(`TILE_DATA_W-8){1'b0}}, core_id_q};
         `CFG_DID_ADDR:     rdata = {{(`TILE_DATA_W-`TILE_DID_W){1'b0}}, did_i};
         default:           rdata = '0;
      endcase
   end

   assign resp_li.cid    = cmd_i.cid;
   assign resp_li.opcode = cmd_i.opcode;
   assign resp_li.addr   = cmd_i.addr;
   assign resp_li.data   = is_store ? '0 : rdata;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         freeze_q  <= 1'b1;
         core_id_q <= 8'd0;
      end
      else if (cmd_yumi_o && is_store)
      begin
         // Tile id and unmapped offsets drop the write
         if (cmd_i.addr == `CFG_FREEZE_ADDR)
            freeze_q <= cmd_i.data[0];
         if (cmd_i.addr == `CFG_CORE_ID_ADDR)
            core_id_q <= cmd_i.data[7:0];
      end
   end

   msg_fifo
   #(
      .payload_t(mem_resp_t)
   )
   u_resp_fifo
   (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .data_i (resp_li),
      .v_i    (cmd_yumi_o),
      .ready_o(resp_room),
      .data_o (resp_o),
      .v_o    (resp_v_o),
      .yumi_i (resp_v_o & resp_ready_i)
   );

   assign freeze_o  = freeze_q;
   assign core_id_o = core_id_q;

endmodule

/* hdl/clint_slice.sv */
`timescale 1ns/1ps

`include "tile_params.svh"

module clint_slice
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  tile_pkg::mem_cmd_t  cmd_i,
   input  logic                cmd_v_i,
   output logic                cmd_yumi_o,
   output tile_pkg::mem_resp_t resp_o,
   output logic                resp_v_o,
   input  logic                resp_ready_i,
   output logic                software_irq_o,
   output logic                timer_irq_o
);

   import tile_pkg::*;

   mem_resp_t               resp_li;
   logic                    resp_room;
   logic                    is_store;
   logic                    wr_msip;
   logic                    wr_mtimecmp;
   logic                    wr_mtime;
   logic [`TILE_DATA_W-1:0] rdata;
   logic                    msip_q;
   logic [`TILE_DATA_W-1:0] mtime_q;
   logic [`TILE_DATA_W-1:0] mtime_n;
   logic [`TILE_DATA_W-1:0] mtimecmp_q;
   logic [`TILE_DATA_W-1:0] mtimecmp_n;
   logic                    timer_irq_q;

   assign cmd_yumi_o = cmd_v_i & resp_room;
   assign is_store   = (cmd_i.opcode == e_mem_store);

   assign wr_msip     = cmd_yumi_o & is_store & (cmd_i.addr == `CLINT_MSIP_ADDR);
   assign wr_mtimecmp = cmd_yumi_o & is_store & (cmd_i.addr == `CLINT_MTIMECMP_ADDR);
   assign wr_mtime    = cmd_yumi_o & is_store & (cmd_i.addr == `CLINT_MTIME_ADDR);

   // A write to mtime replaces that cycle's increment
   assign mtime_n    = wr_mtime ? cmd_i.data : mtime_q + 1'b1;
   assign mtimecmp_n = wr_mtimecmp ? cmd_i.data : mtimecmp_q;

   always_comb
   begin
      case (cmd_i.addr)
         `CLINT_MSIP_ADDR:     rdata = {{(`TILE_DATA_W-1){1'b0}}, msip_q};
         `CLINT_MTIMECMP_ADDR: rdata = mtimecmp_q;
         `CLINT_MTIME_ADDR:    rdata = mtime_q;
         default:              rdata = '0;
      endcase
   end

   assign resp_li.cid    = cmd_i.cid;
   assign resp_li.opcode = cmd_i.opcode;
   assign resp_li.addr   = cmd_i.addr;
   assign resp_li.data   = is_store ? '0 : rdata;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         msip_q      <= 1'b0;
         mtime_q     <= '0;
         mtimecmp_q  <= '1;
         timer_irq_q <= 1'b0;
      end
      else
      begin
         if (wr_msip)
            msip_q <= cmd_i.data[0];
         mtime_q    <= mtime_n;
         mtimecmp_q <= mtimecmp_n;
         // Compare next values so the irq moves with the store's response
         timer_irq_q <= (mtime_n >= mtimecmp_n);
      end
   end

   msg_fifo
   #(
      .payload_t(mem_resp_t)
   )
   u_resp_fifo
   (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .data_i (resp_li),
      .v_i    (cmd_yumi_o),
      .ready_o(resp_room),
      .data_o (resp_o),
      .v_o    (resp_v_o),
      .yumi_i (resp_v_o & resp_ready_i)
   );

   assign software_irq_o = msip_q;
   assign timer_irq_o    = timer_irq_q;

endmodule

/* hdl/io_tile.sv */
`timescale 1ns/1ps

`include "tile_params.svh"

module io_tile
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic [`TILE_DID_W-1:0] did_i,

   input  tile_pkg::mem_cmd_t     cmd_i,
   input  logic                   cmd_v_i,
   output logic                   cmd_ready_o,

   output tile_pkg::mem_resp_t    resp_o,
   output logic                   resp_v_o,
   input  logic                   resp_ready_i,

   output logic                   freeze_o,
   output logic [7:0]             core_id_o,
   output logic                   software_irq_o,
   output logic                   timer_irq_o
);

   import tile_pkg::*;

   mem_cmd_t  cfg_cmd;
   logic      cfg_cmd_v;
   logic      cfg_cmd_yumi;
   mem_resp_t cfg_resp;
   logic      cfg_resp_v;
   logic      cfg_resp_ready;

   mem_cmd_t  clint_cmd;
   logic      clint_cmd_v;
   logic      clint_cmd_yumi;
   mem_resp_t clint_resp;
   logic      clint_resp_v;
   logic      clint_resp_ready;

   mem_concentrator u_mem_concentrator
   (
      .clk_i             (clk_i),
      .rst_n_i           (rst_n_i),
      .cmd_i             (cmd_i),
      .cmd_v_i           (cmd_v_i),
      .cmd_ready_o       (cmd_ready_o),
      .resp_o            (resp_o),
      .resp_v_o          (resp_v_o),
      .resp_ready_i      (resp_ready_i),
      .cfg_cmd_o         (cfg_cmd),
      .cfg_cmd_v_o       (cfg_cmd_v),
      .cfg_cmd_yumi_i    (cfg_cmd_yumi),
      .clint_cmd_o       (clint_cmd),
      .clint_cmd_v_o     (clint_cmd_v),
      .clint_cmd_yumi_i  (clint_cmd_yumi),
      .cfg_resp_i        (cfg_resp),
      .cfg_resp_v_i      (cfg_resp_v),
      .cfg_resp_ready_o  (cfg_resp_ready),
      .clint_resp_i      (clint_resp),
      .clint_resp_v_i    (clint_resp_v),
      .clint_resp_ready_o(clint_resp_ready)
   );

   cfg_regs u_cfg_regs
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cmd_i       (cfg_cmd),
      .cmd_v_i     (cfg_cmd_v),
      .cmd_yumi_o  (cfg_cmd_yumi),
      .resp_o      (cfg_resp),
      .resp_v_o    (cfg_resp_v),
      .resp_ready_i(cfg_resp_ready),
      .did_i       (did_i),
      .freeze_o    (freeze_o),
      .core_id_o   (core_id_o)
   );

   clint_slice u_clint_slice
   (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cmd_i         (clint_cmd),
      .cmd_v_i       (clint_cmd_v),
      .cmd_yumi_o    (clint_cmd_yumi),
      .resp_o        (clint_resp),
      .resp_v_o      (clint_resp_v),
      .resp_ready_i  (clint_resp_ready),
      .software_irq_o(software_irq_o),
      .timer_irq_o   (timer_irq_o)
   );

endmodule

/* dv/io_tile_tb_table.svh */
   // Columns are cid, opcode, addr, wdata, expected rdata, check mode, resp-ready hold,
   // level check flag, expected freeze, core id, software irq, timer irq
   localparam int N_ROWS = 31;

   localparam row_t ROWS [N_ROWS] = '{
      '{CFG, LD, `CFG_FREEZE_ADDR, 64'h0, 64'h1, EQ, 8'd0, Y, Y, 8'h00, N, N},
      '{CFG, ST, `CFG_FREEZE_ADDR, 64'h0, 64'h0, EQ, 8'd0, Y, N, 8'h00, N, N},
      '{CFG, ST, `CFG_CORE_ID_ADDR, 64'h3c, 64'h0, EQ, 8'd0, Y, N, 8'h3c, N, N},
      '{CFG, LD, `CFG_CORE_ID_ADDR, 64'h0, 64'h3c, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CFG, LD, `CFG_DID_ADDR, 64'h0, 64'h5a, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CFG, ST, `CFG_DID_ADDR, 64'hff, 64'h0, EQ, 8'd0, Y, N, 8'h3c, N, N},
      '{CFG, LD, `CFG_DID_ADDR, 64'h0, 64'h5a, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CFG, ST, 16'h0020, 64'hdead, 64'h0, EQ, 8'd0, Y, N, 8'h3c, N, N},
      '{CFG, LD, 16'h0020, 64'h0, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CLT, ST, 16'h0100, 64'hbeef, 64'h0, EQ, 8'd0, Y, N, 8'h3c, N, N},
      '{CLT, LD, 16'h0100, 64'h0, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CLT, ST, `CLINT_MSIP_ADDR, 64'h1, 64'h0, EQ, 8'd0, Y, N, 8'h3c, Y, N},
      '{CLT, LD, `CLINT_MSIP_ADDR, 64'h0, 64'h1, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CLT, ST, `CLINT_MSIP_ADDR, 64'h0, 64'h0, EQ, 8'd0, Y, N, 8'h3c, N, N},
      '{CLT, ST, `CLINT_MTIME_ADDR, 64'h0, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CLT, ST, `CLINT_MTIMECMP_ADDR, 64'hffff_ffff, 64'h0, EQ, 8'd0, Y, N, 8'h3c, N, N},
      '{CLT, LD, `CLINT_MTIME_ADDR, 64'h0, 64'h0, ANY, 8'd0, N, N, 8'h00, N, N},
      '{CLT, LD, `CLINT_MTIME_ADDR, 64'h0, 64'h0, INC, 8'd0, N, N, 8'h00, N, N},
      '{CLT, ST, `CLINT_MTIMECMP_ADDR, 64'h0, 64'h0, EQ, 8'd0, Y, N, 8'h3c, N, Y},
      // Responses held back from here for 40 cycles
      '{CFG, LD, `CFG_CORE_ID_ADDR, 64'h0, 64'h3c, EQ, 8'd40, N, N, 8'h00, N, N},
      '{CLT, LD, `CLINT_MSIP_ADDR, 64'h0, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CFG, LD, `CFG_DID_ADDR, 64'h0, 64'h5a, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CLT, LD, `CLINT_MTIMECMP_ADDR, 64'h0, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CFG, LD, `CFG_FREEZE_ADDR, 64'h0, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CLT, LD, 16'h0100, 64'h0, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CFG, LD, `CFG_CORE_ID_ADDR, 64'h0, 64'h3c, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CLT, LD, `CLINT_MSIP_ADDR, 64'h0, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CFG, ST, `CFG_CORE_ID_ADDR, 64'h81, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CLT, ST, `CLINT_MSIP_ADDR, 64'h1, 64'h0, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CFG, LD, `CFG_CORE_ID_ADDR, 64'h0, 64'h81, EQ, 8'd0, N, N, 8'h00, N, N},
      '{CLT, LD, `CLINT_MSIP_ADDR, 64'h0, 64'h1, EQ, 8'd0, Y, N, 8'h81, Y, Y}
   };

/* dv/io_tile_tb.sv */
`timescale 1ns/1ps

`include "tile_params.svh"

module io_tile_tb;

   import tile_pkg::*;

   localparam logic [`TILE_DID_W-1:0] TILE_DID = 8'h5a;

   // Read data check modes
   localparam logic [1:0] EQ  = 2'd0;
   localparam logic [1:0] ANY = 2'd1;
   localparam logic [1:0] INC = 2'd2;

   localparam logic        CFG = `CID_CFG;
   localparam logic        CLT = `CID_CLINT;
   localparam mem_opcode_e LD  = e_mem_load;
   localparam mem_opcode_e ST  = e_mem_store;
   localparam logic        Y   = 1'b1;
   localparam logic        N   = 1'b0;

   typedef struct packed
   {
      logic                    cid;
      mem_opcode_e             op;
      logic [`TILE_ADDR_W-1:0] addr;
      logic [`TILE_DATA_W-1:0] wdata;
      logic [`TILE_DATA_W-1:0] rdata;
      logic [1:0]              mode;
      logic [7:0]              hold;
      logic                    lvl;
      logic                    freeze;
      logic [7:0]              core_id;
      logic                    sw_irq;
      logic                    tmr_irq;
   } row_t;

   `include "io_tile_tb_table.svh"

   localparam int CYCLE_LIMIT = 40 * N_ROWS + 200;

   logic                    clk;
   logic                    rst_n;
   logic [`TILE_DID_W-1:0]  did;
   mem_cmd_t                cmd;
   logic                    cmd_v;
   logic                    cmd_ready;
   mem_resp_t               resp;
   logic                    resp_v;
   logic                    resp_ready;
   logic                    freeze;
   logic [7:0]              core_id;
   logic                    sw_irq;
   logic                    tmr_irq;

   int                      errors = 0;
   int                      cycle = 0;
   int                      accepted = 0;
   int                      acc_at_hold = 0;
   int                      hold_until = 0;
   int                      responses = 0;
   int                      seed;
   int                      exp_q [2][$];
   logic                    bp_seen = 1'b0;
   logic                    hold_act;
   logic [31:0]             rnd;
   logic                    held_v = 1'b0;
   mem_resp_t               held_resp;
   logic [`TILE_DATA_W-1:0] last_data [2];

   io_tile u_io_tile
   (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .did_i         (did),
      .cmd_i         (cmd),
      .cmd_v_i       (cmd_v),
      .cmd_ready_o   (cmd_ready),
      .resp_o        (resp),
      .resp_v_o      (resp_v),
      .resp_ready_i  (resp_ready),
      .freeze_o      (freeze),
      .core_id_o     (core_id),
      .software_irq_o(sw_irq),
      .timer_irq_o   (tmr_irq)
   );

   always #2 clk = ~clk;

   always @(posedge clk)
      cycle <= cycle + 1;

   task automatic value_mismatch(input string msg);
      errors++;
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
   endtask

   task automatic protocol_error(input string msg);
      errors++;
      $display("ERROR at %0t ns: %s", $time, msg);
   endtask

   task automatic check_response(input mem_resp_t r);
      int   idx;
      row_t row;
      if (exp_q[r.cid].size() == 0)
         protocol_error($sformatf("response for client %0d with no command pending", r.cid));
      else
      begin
         idx = exp_q[r.cid].pop_front();
         row = ROWS[idx];
         responses++;
         assert (r.opcode == row.op && r.addr == row.addr)
         else value_mismatch($sformatf("row %0d opcode %0d addr %h", idx, r.opcode, r.addr));
         if (row.mode == EQ)
         begin
            assert (r.data == row.rdata)
            else value_mismatch($sformatf("row %0d data %h, want %h", idx, r.data, row.rdata));
         end
         else if (row.mode == INC)
         begin
            assert (r.data > last_data[r.cid])
            else value_mismatch($sformatf("row %0d mtime %0d not above %0d", idx, r.data,
                                          last_data[r.cid]));
         end
         last_data[r.cid] = r.data;
         // Outputs already reflect the command by the time its response leaves
         if (row.lvl)
         begin
            assert (freeze == row.freeze && core_id == row.core_id &&
                    sw_irq == row.sw_irq && tmr_irq == row.tmr_irq)
            else value_mismatch($sformatf("row %0d levels %b %h %b %b", idx, freeze, core_id,
                                          sw_irq, tmr_irq));
         end
      end
   endtask

   // Random response back-pressure that a hold window forces low
   always @(posedge clk)
   begin
      hold_act = (cycle < hold_until);
      #0.5;
      rnd = $random(seed);
      resp_ready = hold_act ? 1'b0 : (rnd[1:0] != 2'b00);
   end

   always @(posedge clk)
   begin
      if (rst_n)
      begin
         if (cmd_v && cmd_ready)
            accepted = accepted + 1;
         if (cycle < hold_until && !cmd_ready && !bp_seen)
         begin
            bp_seen = 1'b1;
            assert (accepted - acc_at_hold <= 6)
            else value_mismatch($sformatf("%0d commands taken before cmd_ready_o fell",
                                          accepted - acc_at_hold));
         end
         if (held_v)
         begin
            assert (resp_v && resp == held_resp)
            else value_mismatch("stalled response changed before transfer");
         end
         held_v    = resp_v && !resp_ready;
         held_resp = resp;
         if (resp_v && resp_ready)
            check_response(resp);
      end
   end

   task automatic drain_responses();
      while (exp_q[0].size() + exp_q[1].size() != 0)
      begin
         @(posedge clk);
         #0.5;
      end
   endtask

   task automatic send_row(input int idx);
      cmd.cid    = ROWS[idx].cid;
      cmd.opcode = ROWS[idx].op;
      cmd.addr   = ROWS[idx].addr;
      cmd.data   = ROWS[idx].wdata;
      cmd_v      = 1'b1;
      do
      begin
         @(posedge clk);
      end
      while (!cmd_ready);
      exp_q[ROWS[idx].cid].push_back(idx);
      #0.5;
      cmd_v = 1'b0;
   endtask

   initial
   begin
      seed       = 32'h99a2e5f6;
      clk        = 1'b0;
      rst_n      = 1'b0;
      did        = TILE_DID;
      cmd        = '0;
      cmd_v      = 1'b0;
      resp_ready = 1'b0;
      repeat (8) @(posedge clk);
      #0.5;
      rst_n = 1'b1;
      @(posedge clk);
      #0.5;
      assert (cmd_ready && !resp_v && freeze && core_id == 8'd0 && !sw_irq && !tmr_irq)
      else value_mismatch("outputs after reset");
      for (int i = 0; i < N_ROWS; i++)
      begin
         if (ROWS[i].hold != 8'd0)
         begin
            drain_responses();
            hold_until  = cycle + ROWS[i].hold;
            acc_at_hold = accepted;
         end
         send_row(i);
         if (ROWS[i].lvl)
            drain_responses();
      end
      drain_responses();
      assert (bp_seen)
      else protocol_error("cmd_ready_o never dropped while responses were held");
      assert (responses == N_ROWS)
      else protocol_error($sformatf("%0d responses seen for %0d commands", responses, N_ROWS));
      $display("errors=%0d responses=%0d rows=%0d", errors, responses, N_ROWS);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   initial
   begin
      wait (cycle >= CYCLE_LIMIT);
      $display("Timeout after %0d cycles with responses still outstanding", cycle);
      $display("test failed");
      $finish;
   end

endmodule

/* io_tile.f */
+incdir+hdl
+incdir+dv
hdl/tile_pkg.sv
hdl/msg_fifo.sv
hdl/mem_concentrator.sv
hdl/cfg_regs.sv
hdl/clint_slice.sv
hdl/io_tile.sv
dv/io_tile_tb.sv

/* Bender.yml */
package:
  name: io_tile

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tile_pkg.sv
      - hdl/msg_fifo.sv
      - hdl/mem_concentrator.sv
      - hdl/cfg_regs.sv
      - hdl/clint_slice.sv
      - hdl/io_tile.sv
  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/io_tile_tb.sv
